// File: hw/mmu_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared widths, PTE fields and FSM encodings for the data
// address translation unit. Every RTL block imports it.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package mmu_pkg;

  // Address and page geometry
  localparam int VADDR_W    = 32;
  localparam int PAGE_OFS_W = 12;
  localparam int VPN_W      = 20;
  localparam int PPN_W      = 22;
  localparam int PADDR_W    = 34;
  localparam int PTE_W      = 32;

  localparam int DTLB_ENTRIES = 4;
  localparam int DTLB_IDX_W   = $clog2(DTLB_ENTRIES);

  // PTE field positions
  localparam int PTE_V       = 0;
  localparam int PTE_W_BIT   = 2;
  localparam int PTE_U       = 4;
  localparam int PTE_D       = 7;
  localparam int PTE_PPN_LSB = 10;

  typedef logic [VADDR_W-1:0] vaddr_t;
  typedef logic [VPN_W-1:0]   vpn_t;
  typedef logic [PPN_W-1:0]   ppn_t;
  typedef logic [PADDR_W-1:0] paddr_t;
  typedef logic [PTE_W-1:0]   pte_t;

  typedef enum logic [1:0] {
    PRIV_U = 2'd0,
    PRIV_S = 2'd1,
    PRIV_M = 2'd3
  } priv_e;

  typedef enum logic [1:0] {
    XLATE_IDLE,
    XLATE_LOOKUP,
    XLATE_WALK,
    XLATE_RESP
  } xlate_state_e;

  typedef enum logic [1:0] {
    WALK_IDLE,
    WALK_SETUP,
    WALK_ACCESS
  } walk_state_e;

endpackage

`default_nettype wire

// File: hw/dtlb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fully associative data TLB. Lookup is combinational, fills
// replace entries in round-robin order, flush drops every entry.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module dtlb
  import mmu_pkg::*;
  (input  logic   clk_i
   , input  logic reset_i
   , input  logic flush_i

   , input  vpn_t lookup_vpn_i
   , output logic hit_o
   , output pte_t hit_pte_o

   , input  logic fill_v_i
   , input  vpn_t fill_vpn_i
   , input  pte_t fill_pte_i
   );

  logic [DTLB_ENTRIES-1:0] valid_r;
  vpn_t                    tag_r [DTLB_ENTRIES];
  pte_t                    pte_r [DTLB_ENTRIES];
  logic [DTLB_IDX_W-1:0]   rr_ptr_r;
  logic [DTLB_ENTRIES-1:0] hit_vec;
  pte_t                    hit_pte;

  // Parallel tag compare
  always_comb begin
    hit_pte = '0;
    for (int i = 0; i < DTLB_ENTRIES; i++) begin
      hit_vec[i] = valid_r[i] && (tag_r[i] == lookup_vpn_i);
      if (hit_vec[i]) begin
        hit_pte = hit_pte | pte_r[i];
      end
    end
  end

  assign hit_o     = |hit_vec;
  assign hit_pte_o = hit_pte;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_r  <= '0;
      rr_ptr_r <= '0;
    end else if (flush_i) begin
      valid_r <= '0;
    end else if (fill_v_i) begin
      valid_r[rr_ptr_r] <= 1'b1;
      rr_ptr_r          <= rr_ptr_r + 1'b1;
    end
  end

  // Tag and PTE storage
  always_ff @(posedge clk_i) begin
    if (fill_v_i && !flush_i) begin
      tag_r[rr_ptr_r] <= fill_vpn_i;
      pte_r[rr_ptr_r] <= fill_pte_i;
    end
  end

  // Fills only follow a miss, so no page can be held twice
  a_hit_onehot : assert property (
    @(posedge clk_i) disable iff (reset_i)
    $onehot0(hit_vec)
  );

endmodule

`default_nettype wire

// File: hw/pte_walker.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Single-level page table walker. Each walk_start runs one APB
// read of the PTE and returns it with a done pulse.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module pte_walker
  import mmu_pkg::*;
  (input  logic   clk_i
   , input  logic reset_i

   , input  logic walk_start_i
   , input  vpn_t walk_vpn_i
   , input  ppn_t base_ppn_i

   , output logic   psel_o
   , output logic   penable_o
   , output paddr_t paddr_o
   , input  pte_t   prdata_i
   , input  logic   pready_i
   , input  logic   pslverr_i

   , output logic done_o
   , output pte_t pte_o
   , output logic bus_err_o
   );

  walk_state_e state_r;
  paddr_t      pte_addr;
  paddr_t      paddr_r;
  logic        done_r;
  pte_t        pte_r;
  logic        bus_err_r;
  logic        xfer_done;

  // Base page address plus four bytes per VPN
  assign pte_addr = {base_ppn_i, {PAGE_OFS_W{1'b0}}} + PADDR_W'({walk_vpn_i, 2'b00});

  assign xfer_done = (state_r == WALK_ACCESS) && pready_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= WALK_IDLE;
      done_r  <= 1'b0;
    end else begin
      done_r <= xfer_done;
      case (state_r)
        WALK_IDLE: begin
          if (walk_start_i) begin
            state_r <= WALK_SETUP;
          end
        end
        WALK_SETUP: state_r <= WALK_ACCESS;
        WALK_ACCESS: begin
          if (pready_i) begin
            state_r <= WALK_IDLE;
          end
        end
        default: state_r <= WALK_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if ((state_r == WALK_IDLE) && walk_start_i) begin
      paddr_r <= pte_addr;
    end
    if (xfer_done) begin
      pte_r     <= prdata_i;
      bus_err_r <= pslverr_i;
    end
  end

  assign psel_o    = (state_r != WALK_IDLE);
  assign penable_o = (state_r == WALK_ACCESS);
  assign paddr_o   = paddr_r;
  assign done_o    = done_r;
  assign pte_o     = pte_r;
  assign bus_err_o = bus_err_r;

  // Address and select hold from SETUP until the slave is ready
  a_apb_stable : assert property (
    @(posedge clk_i) disable iff (reset_i)
    (psel_o && !(penable_o && pready_i)) |=> (psel_o && $stable(paddr_o))
  );

endmodule

`default_nettype wire

// File: hw/xlate_ctrl.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Translation sequencer. Accepts one request at a time, looks
// it up in the TLB, walks on a miss, checks permissions and
// holds the response until the requester takes it.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module xlate_ctrl
  import mmu_pkg::*;
  (input  logic     clk_i
   , input  logic   reset_i

   , input  logic   req_v_i
   , input  vaddr_t req_vaddr_i
   , input  logic   req_store_i
   , output logic   req_ready_o

   , output logic   resp_v_o
   , output paddr_t resp_paddr_o
   , output logic   resp_page_fault_o
   , output logic   resp_access_fault_o
   , input  logic   resp_ready_i

   , input  logic   xlate_en_i
   , input  priv_e  priv_i
   , input  logic   sum_i

   , output vpn_t   tlb_vpn_o
   , input  logic   tlb_hit_i
   , input  pte_t   tlb_pte_i

   , output logic   fill_v_o
   , output vpn_t   fill_vpn_o
   , output pte_t   fill_pte_o

   , output logic   walk_start_o
   , output vpn_t   walk_vpn_o
   , input  logic   walk_done_i
   , input  pte_t   walk_pte_i
   , input  logic   walk_bus_err_i
   );

  xlate_state_e state_r;
  xlate_state_e state_n;
  vaddr_t       vaddr_r;
  logic         store_r;
  paddr_t       resp_paddr_r;
  logic         page_fault_r;
  logic         access_fault_r;
  vpn_t         req_vpn;
  ppn_t         hit_ppn;
  logic         priv_fault;
  logic         write_fault;
  logic         walk_ok;

  assign req_vpn = vaddr_r[VADDR_W-1:PAGE_OFS_W];
  assign hit_ppn = tlb_pte_i[PTE_PPN_LSB +: PPN_W];

  // Privilege and store permission rules on the hit entry
  assign priv_fault  = ((priv_i == PRIV_S) && !sum_i && tlb_pte_i[PTE_U])
                     || ((priv_i == PRIV_U) && !tlb_pte_i[PTE_U]);
  assign write_fault = store_r && (!tlb_pte_i[PTE_W_BIT] || !tlb_pte_i[PTE_D]);

  assign walk_ok = walk_done_i && !walk_bus_err_i && walk_pte_i[PTE_V];

  always_comb begin
    state_n = state_r;
    case (state_r)
      XLATE_IDLE: begin
        if (req_v_i) begin
          state_n = XLATE_LOOKUP;
        end
      end
      XLATE_LOOKUP: begin
        if (!xlate_en_i || tlb_hit_i) begin
          state_n = XLATE_RESP;
        end else begin
          state_n = XLATE_WALK;
        end
      end
      XLATE_WALK: begin
        if (walk_done_i) begin
          state_n = walk_ok ? XLATE_LOOKUP : XLATE_RESP;
        end
      end
      XLATE_RESP: begin
        if (resp_ready_i) begin
          state_n = XLATE_IDLE;
        end
      end
      default: state_n = XLATE_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= XLATE_IDLE;
    end else begin
      state_r <= state_n;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_v_i && req_ready_o) begin
      vaddr_r <= req_vaddr_i;
      store_r <= req_store_i;
    end
  end

  // Response capture
  always_ff @(posedge clk_i) begin
    if (state_r == XLATE_LOOKUP) begin
      if (!xlate_en_i) begin
        resp_paddr_r   <= PADDR_W'(vaddr_r);
        page_fault_r   <= 1'b0;
        access_fault_r <= 1'b0;
      end else if (tlb_hit_i) begin
        resp_paddr_r   <= {hit_ppn, vaddr_r[PAGE_OFS_W-1:0]};
        page_fault_r   <= priv_fault || write_fault;
        access_fault_r <= 1'b0;
      end
    end else if ((state_r == XLATE_WALK) && walk_done_i && !walk_ok) begin
      // Bus error outranks an invalid PTE
      resp_paddr_r   <= '0;
      page_fault_r   <= !walk_bus_err_i;
      access_fault_r <= walk_bus_err_i;
    end
  end

  assign req_ready_o         = (state_r == XLATE_IDLE);
  assign resp_v_o            = (state_r == XLATE_RESP);
  assign resp_paddr_o        = resp_paddr_r;
  assign resp_page_fault_o   = page_fault_r;
  assign resp_access_fault_o = access_fault_r;

  assign tlb_vpn_o    = req_vpn;
  assign walk_vpn_o   = req_vpn;
  assign walk_start_o = (state_r == XLATE_LOOKUP) && xlate_en_i && !tlb_hit_i;

  assign fill_v_o   = (state_r == XLATE_WALK) && walk_ok;
  assign fill_vpn_o = req_vpn;
  assign fill_pte_o = walk_pte_i;

  a_resp_stable : assert property (
    @(posedge clk_i) disable iff (reset_i)
    (resp_v_o && !resp_ready_i) |=>
      (resp_v_o && $stable(resp_paddr_o) && $stable(resp_page_fault_o)
       && $stable(resp_access_fault_o))
  );

endmodule

`default_nettype wire

// File: hw/mmu_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Data address translation unit top. Connects the sequencer,
// the data TLB and the APB page table walker.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module mmu_top
  import mmu_pkg::*;
  (input  logic     clk_i
   , input  logic   reset_i

   , input  logic   req_v_i
   , input  vaddr_t req_vaddr_i
   , input  logic   req_store_i
   , output logic   req_ready_o

   , output logic   resp_v_o
   , output paddr_t resp_paddr_o
   , output logic   resp_page_fault_o
   , output logic   resp_access_fault_o
   , input  logic   resp_ready_i

   , input  logic   xlate_en_i
   , input  priv_e  priv_i
   , input  logic   sum_i
   , input  ppn_t   base_ppn_i
   , input  logic   flush_i

   , output logic   psel_o
   , output logic   penable_o
   , output paddr_t paddr_o
   , input  pte_t   prdata_i
   , input  logic   pready_i
   , input  logic   pslverr_i
   );

  vpn_t tlb_vpn;
  logic tlb_hit;
  pte_t tlb_pte;
  logic fill_v;
  vpn_t fill_vpn;
  pte_t fill_pte;
  logic walk_start;
  vpn_t walk_vpn;
  logic walk_done;
  pte_t walk_pte;
  logic walk_bus_err;

  xlate_ctrl ctrl
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.req_v_i(req_v_i)
     ,.req_vaddr_i(req_vaddr_i)
     ,.req_store_i(req_store_i)
     ,.req_ready_o(req_ready_o)
     ,.resp_v_o(resp_v_o)
     ,.resp_paddr_o(resp_paddr_o)
     ,.resp_page_fault_o(resp_page_fault_o)
     ,.resp_access_fault_o(resp_access_fault_o)
     ,.resp_ready_i(resp_ready_i)
     ,.xlate_en_i(xlate_en_i)
     ,.priv_i(priv_i)
     ,.sum_i(sum_i)
     ,.tlb_vpn_o(tlb_vpn)
     ,.tlb_hit_i(tlb_hit)
     ,.tlb_pte_i(tlb_pte)
     ,.fill_v_o(fill_v)
     ,.fill_vpn_o(fill_vpn)
     ,.fill_pte_o(fill_pte)
     ,.walk_start_o(walk_start)
     ,.walk_vpn_o(walk_vpn)
     ,.walk_done_i(walk_done)
     ,.walk_pte_i(walk_pte)
     ,.walk_bus_err_i(walk_bus_err)
     );

  dtlb tlb
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.flush_i(flush_i)
     ,.lookup_vpn_i(tlb_vpn)
     ,.hit_o(tlb_hit)
     ,.hit_pte_o(tlb_pte)
     ,.fill_v_i(fill_v)
     ,.fill_vpn_i(fill_vpn)
     ,.fill_pte_i(fill_pte)
     );

  pte_walker ptw
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.walk_start_i(walk_start)
     ,.walk_vpn_i(walk_vpn)
     ,.base_ppn_i(base_ppn_i)
     ,.psel_o(psel_o)
     ,.penable_o(penable_o)
     ,.paddr_o(paddr_o)
     ,.prdata_i(prdata_i)
     ,.pready_i(pready_i)
     ,.pslverr_i(pslverr_i)
     ,.done_o(walk_done)
     ,.pte_o(walk_pte)
     ,.bus_err_o(walk_bus_err)
     );

endmodule

`default_nettype wire

// File: verif/tb_pte_rule.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Page table contents seen by the testbench. Included inside the
// APB memory model and the testbench so both use the same PTEs.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

localparam int MAX_WAIT_STATES = 3;

// PTE layout: V bit 0, W bit 2, U bit 4, D bit 7, PPN from bit 10
function automatic logic [31:0] pte_of_vpn(input logic [19:0] vpn);
  logic [31:0] pte;
  pte        = '0;
  pte[31:10] = 22'(vpn ^ 20'h2a5a5);
  pte[0]     = (vpn[2:0] != 3'd7);
  pte[4]     = vpn[3];
  pte[2]     = vpn[4];
  pte[7]     = vpn[5];
  return pte;
endfunction

function automatic logic slverr_of_vpn(input logic [19:0] vpn);
  return (vpn[2:0] == 3'd6);
endfunction

// File: verif/pte_mem_model.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// APB slave that serves page table reads from the PTE rule,
// with 0 to 3 random wait states and rule-driven slave errors.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module pte_mem_model
  import mmu_pkg::*;
  (input  logic     clk_i
   , input  logic   reset_i
   , input  ppn_t   base_ppn_i
   , input  logic   psel_i
   , input  logic   penable_i
   , input  paddr_t paddr_i
   , output pte_t   prdata_o
   , output logic   pready_o
   , output logic   pslverr_o
   );

  timeunit 1ns;
  timeprecision 1ps;

  `include "tb_pte_rule.svh"

  pte_t        prdata_r  = '0;
  logic        pready_r  = 1'b0;
  logic        pslverr_r = 1'b0;
  int unsigned wait_left = 0;
  vpn_t        vpn;

  // VPN recovered from the PTE address
  assign vpn = VPN_W'((paddr_i - {base_ppn_i, {PAGE_OFS_W{1'b0}}}) >> 2);

  always @(posedge clk_i) begin
    int unsigned pick;
    logic        respond;
    respond = 1'b0;
    if (reset_i) begin
      pready_r  <= 1'b0;
      pslverr_r <= 1'b0;
      wait_left <= 0;
    end else begin
      pready_r  <= 1'b0;
      pslverr_r <= 1'b0;
      if (psel_i && !penable_i) begin
        // Zero waits means data is ready in the first ACCESS cycle
        pick    = $urandom_range(MAX_WAIT_STATES, 0);
        respond = (pick == 0);
        if (pick != 0) begin
          wait_left <= pick - 1;
        end
      end else if (psel_i && penable_i && !pready_r) begin
        respond = (wait_left == 0);
        if (wait_left != 0) begin
          wait_left <= wait_left - 1;
        end
      end
      if (respond) begin
        pready_r  <= 1'b1;
        prdata_r  <= pte_of_vpn(vpn);
        pslverr_r <= slverr_of_vpn(vpn);
      end
    end
  end

  assign prdata_o  = prdata_r;
  assign pready_o  = pready_r;
  assign pslverr_o = pslverr_r;

endmodule

`default_nettype wire

// File: verif/mmu_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the translation unit. Sends bypass, hit, miss,
// fault, flush and eviction traffic and checks every response.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module mmu_tb
  import mmu_pkg::*;
  ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned SEED       = 32'he488_cf83;
  localparam int          CLK_PERIOD = 4;
  localparam int          TIMEOUT    = 200;
  localparam ppn_t        BASE_PPN   = 22'h2b3c1;

  `include "tb_pte_rule.svh"

  logic   clk = 1'b0;
  logic   reset;
  logic   req_v;
  vaddr_t req_vaddr;
  logic   req_store;
  logic   req_ready;
  logic   resp_v;
  paddr_t resp_paddr;
  logic   resp_page_fault;
  logic   resp_access_fault;
  logic   resp_ready;
  logic   xlate_en;
  priv_e  priv;
  logic   sum;
  ppn_t   base_ppn;
  logic   flush;
  logic   psel;
  logic   penable;
  paddr_t paddr;
  pte_t   prdata;
  logic   pready;
  logic   pslverr;

  int     value_errors;
  int     proto_errors  = 0;
  int     apb_reads     = 0;
  paddr_t last_apb_addr = '0;
  vpn_t   tlb_model[$];
  logic   random_ready;

  always #(CLK_PERIOD / 2) clk = ~clk;

  mmu_top uut
    (.clk_i(clk)
     ,.reset_i(reset)
     ,.req_v_i(req_v)
     ,.req_vaddr_i(req_vaddr)
     ,.req_store_i(req_store)
     ,.req_ready_o(req_ready)
     ,.resp_v_o(resp_v)
     ,.resp_paddr_o(resp_paddr)
     ,.resp_page_fault_o(resp_page_fault)
     ,.resp_access_fault_o(resp_access_fault)
     ,.resp_ready_i(resp_ready)
     ,.xlate_en_i(xlate_en)
     ,.priv_i(priv)
     ,.sum_i(sum)
     ,.base_ppn_i(base_ppn)
     ,.flush_i(flush)
     ,.psel_o(psel)
     ,.penable_o(penable)
     ,.paddr_o(paddr)
     ,.prdata_i(prdata)
     ,.pready_i(pready)
     ,.pslverr_i(pslverr)
     );

  pte_mem_model mem
    (.clk_i(clk)
     ,.reset_i(reset)
     ,.base_ppn_i(base_ppn)
     ,.psel_i(psel)
     ,.penable_i(penable)
     ,.paddr_i(paddr)
     ,.prdata_o(prdata)
     ,.pready_o(pready)
     ,.pslverr_o(pslverr)
     );

  // One SETUP phase per APB read
  always @(posedge clk) begin
    if (!reset && psel && !penable) begin
      apb_reads     <= apb_reads + 1;
      last_apb_addr <= paddr;
    end
  end

  a_resp_hold : assert property (
    @(posedge clk) disable iff (reset)
    (resp_v && !resp_ready) |=> (resp_v && $stable(resp_paddr)
      && $stable(resp_page_fault) && $stable(resp_access_fault))
  ) else begin
    proto_errors = proto_errors + 1;
    $display("error %0t: response changed while stalled", $time);
  end

  a_busy_while_resp : assert property (
    @(posedge clk) disable iff (reset)
    resp_v |-> !req_ready
  ) else begin
    proto_errors = proto_errors + 1;
    $display("error %0t: request accepted while a response is pending", $time);
  end

  a_no_walk_in_bypass : assert property (
    @(posedge clk) disable iff (reset)
    !xlate_en |-> !psel
  ) else begin
    proto_errors = proto_errors + 1;
    $display("error %0t: APB read with translation disabled", $time);
  end

  // UWD from k, low bits k+1, so k=5 gets a slave error and k=6 an invalid PTE
  function automatic vpn_t page_vpn(input int k);
    return {14'h1d2b, 3'(k), 3'(k + 1)};
  endfunction

  function automatic vaddr_t page_va(input int k);
    return {page_vpn(k), 12'($urandom())};
  endfunction

  function automatic priv_e priv_pick(input int n);
    case (n)
      0: return PRIV_U;
      1: return PRIV_S;
      default: return PRIV_M;
    endcase
  endfunction

  // Page table starts on a 4 KiB page, one 4-byte entry per VPN
  function automatic paddr_t pte_addr_of(input vpn_t vpn);
    paddr_t table_base;
    table_base = PADDR_W'(BASE_PPN) * 4096;
    return table_base + PADDR_W'(vpn) * 4;
  endfunction

  function automatic logic access_denied(input pte_t pte, input logic store,
                                         input priv_e pm, input logic su);
    if ((pm == PRIV_S) && !su && pte[PTE_U]) begin
      return 1'b1;
    end
    if ((pm == PRIV_U) && !pte[PTE_U]) begin
      return 1'b1;
    end
    return store && !(pte[PTE_W_BIT] && pte[PTE_D]);
  endfunction

  function automatic logic in_tlb_model(input vpn_t vpn);
    foreach (tlb_model[i]) begin
      if (tlb_model[i] == vpn) begin
        return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  // Round-robin over all entries always replaces the oldest fill
  task automatic remember_fill(input vpn_t vpn);
    tlb_model.push_back(vpn);
    if (tlb_model.size() > DTLB_ENTRIES) begin
      void'(tlb_model.pop_front());
    end
  endtask

  task automatic note_error(input string msg);
    value_errors++;
    $display("error %0t: %s", $time, msg);
  endtask

  task automatic abort_on_timeout(input string what);
    $display("timed out waiting for %s at %0t", what, $time);
    $display("Test failed");
    $finish;
  endtask

  task automatic apply_flush();
    flush <= 1'b1;
    @(posedge clk);
    flush <= 1'b0;
    tlb_model.delete();
  endtask

  task automatic translate(input vaddr_t va, input logic store, input priv_e pm,
                           input logic su, input logic en);
    vpn_t   vpn;
    pte_t   pte;
    logic   hit;
    int     reads_before;
    int     exp_reads;
    int     polls;
    int     first_seen;
    logic   handshake;
    paddr_t exp_paddr;
    logic   exp_pf;
    logic   exp_af;
    paddr_t got_paddr;
    logic   got_pf;
    logic   got_af;
    vpn          = va[VADDR_W-1:PAGE_OFS_W];
    pte          = pte_of_vpn(vpn);
    hit          = en && in_tlb_model(vpn);
    reads_before = apb_reads;
    exp_reads    = (en && !hit) ? 1 : 0;
    exp_paddr    = PADDR_W'(va);
    exp_pf       = 1'b0;
    exp_af       = 1'b0;
    if (en) begin
      exp_paddr = {pte[PTE_PPN_LSB +: PPN_W], va[PAGE_OFS_W-1:0]};
      if (!hit && slverr_of_vpn(vpn)) begin
        exp_af = 1'b1;
      end else if (!pte[PTE_V]) begin
        exp_pf = 1'b1;
      end else begin
        exp_pf = access_denied(pte, store, pm, su);
        if (!hit) begin
          remember_fill(vpn);
        end
      end
    end

    xlate_en  <= en;
    priv      <= pm;
    sum       <= su;
    req_vaddr <= va;
    req_store <= store;
    req_v     <= 1'b1;
    polls = 0;
    do begin
      @(posedge clk);
      polls++;
      if (polls > TIMEOUT) begin
        abort_on_timeout("request accept");
      end
    end while (!req_ready);
    req_v <= 1'b0;

    polls      = 0;
    first_seen = 0;
    do begin
      @(posedge clk);
      polls++;
      if (polls > TIMEOUT) begin
        abort_on_timeout("translation response");
      end
      if (resp_v && (first_seen == 0)) begin
        first_seen = polls;
      end
      got_paddr  = resp_paddr;
      got_pf     = resp_page_fault;
      got_af     = resp_access_fault;
      handshake  = resp_v && resp_ready;
      resp_ready <= random_ready ? ($urandom_range(1, 0) == 1) : 1'b1;
    end while (!handshake);

    assert ((got_pf === exp_pf) && (got_af === exp_af))
      else note_error($sformatf("va %h faults page %b access %b, expected %b %b",
                                va, got_pf, got_af, exp_pf, exp_af));
    if (!exp_pf && !exp_af) begin
      assert (got_paddr === exp_paddr)
        else note_error($sformatf("va %h paddr %h, expected %h", va, got_paddr, exp_paddr));
    end
    assert ((apb_reads - reads_before) == exp_reads)
      else note_error($sformatf("va %h made %0d APB reads, expected %0d",
                                va, apb_reads - reads_before, exp_reads));
    if (exp_reads == 1) begin
      assert (last_apb_addr === pte_addr_of(vpn))
        else note_error($sformatf("va %h read PTE at %h, expected %h",
                                  va, last_apb_addr, pte_addr_of(vpn)));
    end else begin
      // Seen on the second poll means it rose on the first edge after accept
      assert (first_seen == 2)
        else note_error($sformatf("va %h response seen on poll %0d, expected 2",
                                  va, first_seen));
    end
  endtask

  initial begin
    int unsigned seed_ret;
    seed_ret     = $urandom(SEED);
    value_errors = 0;
    random_ready = 1'b0;
    reset      <= 1'b1;
    req_v      <= 1'b0;
    req_vaddr  <= '0;
    req_store  <= 1'b0;
    resp_ready <= 1'b1;
    xlate_en   <= 1'b0;
    priv       <= PRIV_M;
    sum        <= 1'b0;
    base_ppn   <= BASE_PPN;
    flush      <= 1'b0;
    repeat (5) @(posedge clk);
    reset <= 1'b0;

    for (int i = 0; i < 4; i++) begin
      translate($urandom(), 1'($urandom_range(1, 0)), PRIV_S, 1'b0, 1'b0);
    end

    // Miss then hit on a fully permissive page
    translate(page_va(7), 1'b1, PRIV_M, 1'b0, 1'b1);
    translate(page_va(7), 1'b1, PRIV_M, 1'b0, 1'b1);

    // Faulting walks leave the TLB alone
    for (int i = 0; i < 2; i++) begin
      translate(page_va(5), 1'b0, PRIV_M, 1'b0, 1'b1);
      translate(page_va(6), 1'b0, PRIV_M, 1'b0, 1'b1);
    end

    apply_flush();
    translate(page_va(7), 1'b0, PRIV_S, 1'b1, 1'b1);

    // Five pages through four entries
    apply_flush();
    for (int i = 0; i < 5; i++) begin
      translate(page_va(i), 1'b0, PRIV_M, 1'b0, 1'b1);
    end
    translate(page_va(0), 1'b0, PRIV_M, 1'b0, 1'b1);

    random_ready = 1'b1;
    for (int i = 0; i < 120; i++) begin
      if ($urandom_range(11, 0) == 0) begin
        apply_flush();
      end
      translate(page_va(int'($urandom_range(7, 0))), 1'($urandom_range(1, 0)),
                priv_pick(int'($urandom_range(2, 0))), 1'($urandom_range(1, 0)),
                ($urandom_range(3, 0) != 0));
    end

    repeat (2) @(posedge clk);
    $display("value errors %0d, protocol errors %0d", value_errors, proto_errors);
    if ((value_errors == 0) && (proto_errors == 0)) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: files.f
+incdir+verif
hw/mmu_pkg.sv
hw/dtlb.sv
hw/pte_walker.sv
hw/xlate_ctrl.sv
hw/mmu_top.sv
verif/pte_mem_model.sv
verif/mmu_tb.sv

// File: Makefile
# Verilator build and run of the translation unit testbench

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f files.f --top-module mmu_tb -Mdir obj_dir -o mmu_tb_sim
	./obj_dir/mmu_tb_sim | tee sim.log
	grep -q "Test completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
